/* bench/tb_stack_cpu.sv */
`default_nettype none

// Directed testbench for the stack machine core
module tb_stack_cpu
   import isa_pkg::*;
   import mem_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int    CLK_PERIOD      = 4;
   localparam int    N_TESTS         = 6;
   localparam int    CYCLES_PER_TEST = 200;
   localparam int    ACK_LIMIT       = 150;     // Longest host wait
   localparam int    BUSY_LIMIT      = 120;     // Longest program run
   localparam addr_t DATA_BASE       = 12'h900; // Host test words
   localparam addr_t ST_ADDR         = 12'h7A0; // LD and ST target
   localparam addr_t CNT_ADDR        = 12'h880; // Loop counter variable
   localparam imm_t  MARK            = 12'h3C7; // Written after return

   logic  clk;
   logic  reset;
   logic  run;
   logic  busy;
   word_t in_port0, in_port1, in_port2, in_port3;
   word_t out_port0, out_port1, out_port2, out_port3;
   logic  wb_cyc, wb_stb, wb_we;
   addr_t wb_adr;
   word_t wb_dat_w;
   word_t wb_dat_r;
   logic  wb_ack;

   int     errors;
   int     checks;
   integer seed;
   word_t  prog [$];     // Program under construction
   int     halt_off;     // HALT position inside prog
   addr_t  base;         // Load address, tracks the stopped PC

   stack_cpu_top u_dut (
      .clk(clk), .reset(reset), .run(run), .busy(busy),
      .in_port0(in_port0), .in_port1(in_port1), .in_port2(in_port2), .in_port3(in_port3),
      .out_port0(out_port0), .out_port1(out_port1),
      .out_port2(out_port2), .out_port3(out_port3),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Whole run bounded by the test count
   initial
   begin
      #(N_TESTS * CYCLES_PER_TEST * CLK_PERIOD);
      $display("Timeout: tests still running after %0d cycles", N_TESTS * CYCLES_PER_TEST);
      $display("Simulation FAILED");
      $finish;
   end

   ////////////////////
   // Compare tasks
   task automatic check_word(input string what, input word_t got, input word_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0d ns: %s is %05h, expected %05h", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("ERR %0d ns: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      $display("%-14s %0d errors", name, errors - errs_before);
   endtask

   ////////////////////
   // Encoding and operands
   function automatic word_t encode_instr(input opcode_e op, input imm_t imm);
      return {2'b00, op, imm};
   endfunction

   function automatic word_t encode_alu(input alu_func_e f);
      return {2'b00, OP, 7'b0, f};   // Function in the low bits
   endfunction

   function automatic imm_t rand12();
      return imm_t'($random(seed));
   endfunction

   function automatic word_t sext12(input imm_t v);
      return {{(WORD_W - IMM_W){v[IMM_W-1]}}, v};
   endfunction

   ////////////////////
   // Wishbone host
   task automatic wb_access(input logic we, input addr_t adr, input word_t wdat,
                            output word_t rdat, output int waits);
      int n;
      n        = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_w = wdat;
      @(posedge clk);
      #1;
      while (!wb_ack && n < ACK_LIMIT)   // Held off while busy
      begin
         n++;
         @(posedge clk);
         #1;
      end
      if (!wb_ack)
      begin
         errors++;
         $display("No Wishbone ack for address %03h after %0d cycles", adr, n);
      end
      rdat  = wb_dat_r;                  // Valid during ack
      waits = n;
      @(posedge clk);                    // Strobe kept through the ack edge
      #1;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic wb_write(input addr_t adr, input word_t data);
      word_t rdat_dummy;
      int    waits;
      wb_access(1'b1, adr, data, rdat_dummy, waits);
   endtask

   task automatic wb_read(input addr_t adr, output word_t data);
      int waits;
      wb_access(1'b0, adr, '0, data, waits);
   endtask

   ////////////////////
   // Program handling
   task automatic new_program();
      prog.delete();
   endtask

   task automatic emit(input word_t w);
      prog.push_back(w);
   endtask

   task automatic emit_halt();
      halt_off = prog.size();
      prog.push_back(encode_instr(HALT, imm_t'(0)));
   endtask

   task automatic load_program();
      for (int i = 0; i < prog.size(); i++)
         wb_write(base + addr_t'(i), prog[i]);
   endtask

   task automatic start_run();
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      check_bit("busy after run", busy, 1'b1);
   endtask

   task automatic wait_idle();
      int n;
      n = 0;
      while (busy && n < BUSY_LIMIT)
      begin
         n++;
         @(posedge clk);
         #1;
      end
      if (busy)
      begin
         errors++;
         $display("Program at %03h did not halt within %0d cycles", base, BUSY_LIMIT);
      end
      base = base + addr_t'(halt_off);   // Next run starts at the HALT
   endtask

   task automatic run_program();
      load_program();
      start_run();
      wait_idle();
   endtask

   ////////////////////
   // Tests
   task automatic test_reset_state();
      int errs0;
      errs0 = errors;
      check_bit("busy", busy, 1'b0);
      check_bit("wb_ack", wb_ack, 1'b0);
      check_word("out_port0", out_port0, '0);
      check_word("out_port1", out_port1, '0);
      check_word("out_port2", out_port2, '0);
      check_word("out_port3", out_port3, '0);
      report_test("reset", errs0);
   endtask

   task automatic test_host_access();
      word_t wdata [8];
      word_t rdata;
      int    waits;
      int    errs0;
      errs0 = errors;
      for (int i = 0; i < 8; i++)
      begin
         wdata[i] = word_t'($random(seed));
         wb_write(DATA_BASE + addr_t'(i), wdata[i]);
      end
      for (int i = 0; i < 8; i++)
      begin
         wb_read(DATA_BASE + addr_t'(i), rdata);
         check_word($sformatf("ram[%03h]", DATA_BASE + addr_t'(i)), rdata, wdata[i]);
      end
      // Twelve PUSHI keep the core busy
      new_program();
      for (int i = 0; i < 12; i++)
         emit(encode_instr(PUSHI, imm_t'(i)));
      emit_halt();
      load_program();
      start_run();
      wb_access(1'b0, DATA_BASE, '0, rdata, waits);
      check_bit("busy at ack", busy, 1'b0);
      check_bit("ack held off", waits >= 12, 1'b1);
      check_word("read after run", rdata, wdata[0]);
      wait_idle();
      report_test("host access", errs0);
   endtask

   task automatic alu_case(input string what, input alu_func_e f, input imm_t x,
                           input imm_t y, input word_t exp);
      new_program();
      emit(encode_instr(PUSHI, x));      // Next
      emit(encode_instr(PUSHI, y));      // Top
      emit(encode_alu(f));
      emit(encode_instr(OUT, imm_t'(0)));
      emit_halt();
      run_program();
      check_word(what, out_port0, exp);
   endtask

   task automatic test_alu();
      imm_t  x, y, sh;
      word_t xs, ys;
      int    errs0;
      errs0 = errors;
      x  = rand12();
      y  = rand12();
      sh = imm_t'($random(seed) & 7);    // Small shift count
      xs = sext12(x);
      ys = sext12(y);
      alu_case("ADD", ADD, x, y, xs + ys);
      alu_case("SUB", SUB, x, y, xs - ys);
      alu_case("SHL", SHL, x, sh, xs << sh);
      alu_case("BAND", BAND, x, y, xs & ys);
      alu_case("BXOR", BXOR, x, y, xs ^ ys);
      alu_case("LT", LT, x, y, ($signed(xs) < $signed(ys)) ? word_t'(1) : word_t'(0));
      alu_case("LT swapped", LT, y, x, ($signed(ys) < $signed(xs)) ? word_t'(1) : word_t'(0));
      alu_case("NEG", NEG, x, y, -ys);
      report_test("alu", errs0);
   endtask

   task automatic test_multiply();
      imm_t                       x, y;
      logic signed [2*WORD_W-1:0] prod;
      logic signed [2*WORD_W-1:0] shifted;
      word_t                      exp;
      int                         errs0;
      errs0 = errors;
      for (int i = 0; i < 10; i++)
      begin
         x       = rand12();
         y       = rand12();
         prod    = $signed(sext12(x)) * $signed(sext12(y));
         shifted = prod >>> FRAC_BITS;           // Drop 8 fraction bits
         exp     = {prod[2*WORD_W-1], shifted[WORD_W-2:0]};
         alu_case($sformatf("MUL %0d", i), MUL, x, y, exp);
      end
      report_test("multiply", errs0);
   endtask

   task automatic test_mem_ports();
      word_t din;
      word_t rdata;
      int    errs0;
      errs0    = errors;
      din      = word_t'($random(seed));
      in_port0 = ~din;                    // Wrong ports hold other values
      in_port1 = din ^ 18'h15555;
      in_port2 = din;
      in_port3 = din + 18'd1;
      new_program();
      emit(encode_instr(PUSHI, ST_ADDR));
      emit(encode_instr(IN, imm_t'(2)));
      emit(encode_instr(ST, imm_t'(0)));   // Data on top, address under it
      emit(encode_instr(PUSHI, ST_ADDR));
      emit(encode_instr(LD, imm_t'(0)));
      emit(encode_alu(DUP));
      emit(encode_alu(ADD));
      emit(encode_instr(OUT, imm_t'(1)));
      emit_halt();
      run_program();
      check_word("out_port1", out_port1, din + din);
      wb_read(ST_ADDR, rdata);
      check_word("stored word", rdata, din);
      report_test("memory ports", errs0);
   endtask

   task automatic test_control_flow();
      int n;
      int errs0;
      errs0 = errors;
      n     = 3 + ($random(seed) & 3);
      new_program();
      emit(encode_instr(PUSHI, imm_t'(0)));         // 0
      emit(encode_instr(POP, CNT_ADDR));            // 1  Count cleared
      emit(encode_instr(PUSHI, imm_t'(n)));         // 2
      emit(encode_instr(PUSH, CNT_ADDR));           // 3  Loop head
      emit(encode_instr(PUSHI, imm_t'(1)));         // 4
      emit(encode_alu(ADD));                        // 5
      emit(encode_instr(POP, CNT_ADDR));            // 6
      emit(encode_instr(PUSHI, imm_t'(1)));         // 7
      emit(encode_alu(SUB));                        // 8  Count down
      emit(encode_alu(DUP));                        // 9
      emit(encode_instr(JNZ, base + addr_t'(3)));   // 10
      emit(encode_alu(DROP));                       // 11
      emit(encode_instr(PUSH, CNT_ADDR));           // 12
      emit(encode_instr(OUT, imm_t'(0)));           // 13
      emit(encode_instr(PPPC, imm_t'(0)));          // 14 PUSHPC
      emit(encode_instr(JMP, base + addr_t'(19)));  // 15 Call
      emit(encode_instr(PUSHI, MARK));              // 16 Return lands here
      emit(encode_instr(OUT, imm_t'(3)));           // 17
      emit_halt();                                  // 18
      emit(encode_instr(PUSHI, imm_t'(1)));         // 19 Skip the call word
      emit(encode_alu(ADD));                        // 20
      emit(encode_instr(PPPC, imm_t'(1)));          // 21 POPPC
      run_program();
      check_word("iterations", out_port0, word_t'(n));
      check_word("marker", out_port3, sext12(MARK));
      report_test("control flow", errs0);
   endtask

   ////////////////////
   // Main sequence
   initial
   begin
      reset    = 1'b0;
      run      = 1'b0;
      in_port0 = '0;
      in_port1 = '0;
      in_port2 = '0;
      in_port3 = '0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_w = '0;
      errors   = 0;
      checks   = 0;
      seed     = 70130;
      base     = '0;                    // PC is zero after reset
      halt_off = 0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b1;

      test_reset_state();
      test_host_access();
      test_alu();
      test_multiply();
      test_mem_ports();
      test_control_flow();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* logic/cpu_control.sv */
`default_nettype none

// Run sequencer, program counter and instruction decode
module cpu_control
   import isa_pkg::*;
   import mem_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   input  wire        run,
   output logic       busy,
   stack_if.ctrl      stk,
   input  wire word_t instr,
   input  wire word_t ram_q,
   input  wire word_t alu_s,
   input  wire word_t in_data,
   output alu_func_e  func,
   output addr_t      pc_next,
   output addr_t      abus,
   output word_t      dbus,
   output logic       ram_we,
   output logic       out_we,
   output port_sel_t  port_sel
);

   run_state_e state;
   addr_t      pc;
   opcode_e    opcode;
   imm_t       imm;
   logic       halt, pcinc, jump, poppc, pushpc;
   logic       ir2abus, qtop2abus, qnext2abus;   // Address source
   logic       ir2dbus, qtop2dbus, alu2dbus, in2dbus;

   assign opcode   = opcode_e'(instr[OPC_MSB:OPC_LSB]);
   assign imm      = instr[IMM_W-1:0];
   assign func     = alu_func_e'(instr[FUNC_MSB:0]);
   assign port_sel = port_sel_t'(instr[PORT_MSB:0]);
   assign busy     = (state != IDLE_A);

   ////////////////////
   // Run sequencer
   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         state <= IDLE_A;
      else
         case (state)
            IDLE_A:  if (run) state <= IDLE_B;
            IDLE_B:  state <= EXEC;        // First word fetched here
            EXEC:    if (halt) state <= IDLE_A;
            default: state <= IDLE_A;
         endcase
   end

   ////////////////////
   // Program counter
   always_comb
   begin
      if (pcinc)
         pc_next = pc + addr_t'(1);
      else if (jump)
         pc_next = imm;
      else if (poppc)
         pc_next = stk.qtop[ADDR_W-1:0];   // Return address
      else
         pc_next = pc;                     // Idle fetch holds the start word
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         pc <= '0;
      else if (pcinc || jump || poppc)
         pc <= pc_next;
   end

   ////////////////////
   // Decode
   always_comb
   begin
      halt       = 1'b0;
      pcinc      = 1'b0;
      jump       = 1'b0;
      poppc      = 1'b0;
      pushpc     = 1'b0;
      ir2abus    = 1'b0;
      qtop2abus  = 1'b0;
      qnext2abus = 1'b0;
      ir2dbus    = 1'b0;
      qtop2dbus  = 1'b0;
      alu2dbus   = 1'b0;
      in2dbus    = 1'b0;
      ram_we     = 1'b0;
      out_we     = 1'b0;
      stk.push   = 1'b0;
      stk.pop    = 1'b0;
      stk.pop2   = 1'b0;
      stk.load   = 1'b0;
      stk.thru   = 1'b0;
      if (state == EXEC)
         case (opcode)
            HALT: halt = 1'b1;
            PUSHI:
            begin
               ir2dbus  = 1'b1;
               stk.load = 1'b1;
               stk.push = 1'b1;
               pcinc    = 1'b1;
            end
            PUSH:
            begin
               ir2abus  = 1'b1;
               stk.push = 1'b1;
               stk.thru = 1'b1;   // Word arrives next cycle
               pcinc    = 1'b1;
            end
            POP:
            begin
               ir2abus   = 1'b1;
               qtop2dbus = 1'b1;
               ram_we    = 1'b1;
               stk.pop   = 1'b1;
               pcinc     = 1'b1;
            end
            JMP: jump = 1'b1;
            JZ, JNZ:
            begin
               if ((stk.qtop == '0) == (opcode == JZ))
                  jump = 1'b1;
               else
                  pcinc = 1'b1;
               stk.pop = 1'b1;    // Condition always consumed
            end
            LD:
            begin
               qtop2abus = 1'b1;
               stk.thru  = 1'b1;
               pcinc     = 1'b1;
            end
            ST:
            begin
               qnext2abus = 1'b1;   // Address under the data
               qtop2dbus  = 1'b1;
               ram_we     = 1'b1;
               stk.pop2   = 1'b1;
               pcinc      = 1'b1;
            end
            PPPC:
               if (!instr[0])
               begin
                  pushpc   = 1'b1;
                  stk.load = 1'b1;
                  stk.push = 1'b1;
                  pcinc    = 1'b1;
               end
               else
               begin
                  poppc   = 1'b1;
                  stk.pop = 1'b1;
               end
            IN:
            begin
               in2dbus  = 1'b1;
               stk.load = 1'b1;
               stk.push = 1'b1;
               pcinc    = 1'b1;
            end
            OUT:
            begin
               qtop2dbus = 1'b1;
               out_we    = 1'b1;
               stk.pop   = 1'b1;
               pcinc     = 1'b1;
            end
            OP:
            begin
               alu2dbus = 1'b1;
               stk.load = 1'b1;
               pcinc    = 1'b1;
               if (!instr[FUNC_MSB])
                  stk.pop = 1'b1;   // Binary ops
               case (func)
                  DUP, OVER:      stk.push = 1'b1;
                  DROP, DROPNEXT: stk.pop = 1'b1;
                  default: ;
               endcase
            end
            default: pcinc = 1'b1;   // Spare codes skip
         endcase
   end

   ////////////////////
   // Bus selection
   always_comb
   begin
      if (ir2abus)
         abus = imm;
      else if (qtop2abus)
         abus = stk.qtop[ADDR_W-1:0];
      else if (qnext2abus)
         abus = stk.qnext[ADDR_W-1:0];
      else
         abus = '0;
   end

   always_comb
   begin
      if (ir2dbus)
         dbus = {{(WORD_W-IMM_W){imm[IMM_W-1]}}, imm};   // Sign extended
      else if (qtop2dbus)
         dbus = stk.qtop;
      else if (alu2dbus)
         dbus = alu_s;
      else if (in2dbus)
         dbus = in_data;
      else if (pushpc)
         dbus = word_t'(pc_next);
      else
         dbus = '0;
   end

   assign stk.d = dbus;

   // Fetched words are never uninitialised while running
   a_opcode_known: assert property (@(posedge clk) disable iff (!reset)
      (state == EXEC) |-> !$isunknown(instr[OPC_MSB:OPC_LSB]));

endmodule

`default_nettype wire

/* logic/data_stack.sv */
`default_nettype none

// Eight entry data stack, grows downward
module data_stack
   import isa_pkg::*;
   import mem_pkg::*;
(
   input  wire    clk,
   input  wire    reset,
   stack_if.stk   stk
);

   word_t mem [STACK_DEPTH];
   sp_t   sp;           // Points at top entry
   sp_t   sp_nxt;
   sp_t   sp_under;     // Entry just below new top
   logic  thru_q;       // RAM data is the top this cycle
   logic  thru_write;

   always_comb
   begin
      if (stk.push)
         sp_nxt = sp - sp_t'(1);
      else if (stk.pop)
         sp_nxt = sp + sp_t'(1);
      else if (stk.pop2)
         sp_nxt = sp + sp_t'(2);
      else
         sp_nxt = sp;
   end

   assign sp_under   = sp_nxt + sp_t'(1);
   assign thru_write = thru_q && !(stk.push || stk.pop || stk.pop2);   // Keep fetched top

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
      begin
         sp     <= '0;
         thru_q <= 1'b0;
      end
      else
      begin
         sp     <= sp_nxt;
         thru_q <= stk.thru;
      end
   end

   always_ff @(posedge clk)
   begin
      if (stk.load)
         mem[sp_nxt] <= stk.d;
      else if (thru_write)
         mem[sp_nxt] <= stk.dthru;
      if (stk.push && thru_q)
         mem[sp_under] <= stk.dthru;   // Fetched word slides under
   end

   assign stk.qtop  = thru_q ? stk.dthru : mem[sp];
   assign stk.qnext = mem[sp + sp_t'(1)];

   // Decoder never grows and shrinks at once
   a_push_pop: assert property (@(posedge clk) disable iff (!reset)
      !(stk.push && (stk.pop || stk.pop2)));

endmodule

`default_nettype wire

/* logic/io_ports.sv */
`default_nettype none

// Output registers and input select
module io_ports
   import isa_pkg::*;
   import mem_pkg::*;
(
   input  wire            clk,
   input  wire            reset,
   input  wire            out_we,
   input  wire port_sel_t port_sel,
   input  wire word_t     dbus,
   input  wire word_t     in_port0,
   input  wire word_t     in_port1,
   input  wire word_t     in_port2,
   input  wire word_t     in_port3,
   output word_t          in_data,
   output word_t          out_port0,
   output word_t          out_port1,
   output word_t          out_port2,
   output word_t          out_port3
);

   word_t out_q [N_PORTS];
   word_t in_w  [N_PORTS];

   assign in_w[0] = in_port0;
   assign in_w[1] = in_port1;
   assign in_w[2] = in_port2;
   assign in_w[3] = in_port3;
   assign in_data = in_w[port_sel];

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         out_q <= '{default: '0};
      else if (out_we)
         out_q[port_sel] <= dbus;   // OUT pops into the port
   end

   assign out_port0 = out_q[0];
   assign out_port1 = out_q[1];
   assign out_port2 = out_q[2];
   assign out_port3 = out_q[3];

endmodule

`default_nettype wire

/* logic/isa_pkg.sv */
`default_nettype none

// Instruction set of the 18-bit stack machine
package isa_pkg;

   localparam int WORD_W    = 18;   // Data and instruction word
   localparam int IMM_W     = 12;   // Immediate and jump target
   localparam int FRAC_BITS = 8;    // 10.8 fixed point multiply

   // Field positions inside an instruction word
   localparam int OPC_MSB  = 15;
   localparam int OPC_LSB  = 12;
   localparam int FUNC_MSB = 4;    // ALU function at [4:0]
   localparam int PORT_MSB = 2;    // Port number at [2:0]

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [IMM_W-1:0]  imm_t;

   typedef enum logic [3:0] {
      HALT  = 4'b0000,
      PUSHI = 4'b0001,
      PUSH  = 4'b0010,
      POP   = 4'b0011,
      JMP   = 4'b0100,
      JZ    = 4'b0101,
      JNZ   = 4'b0110,
      LD    = 4'b0111,
      ST    = 4'b1000,
      PPPC  = 4'b1001,   // Bit 0 picks PUSHPC or POPPC
      IN    = 4'b1101,
      OUT   = 4'b1110,
      OP    = 4'b1111
   } opcode_e;

   // Bit 4 clear means binary op on next and top
   typedef enum logic [4:0] {
      ADD = 5'd0,  SUB = 5'd1,  MUL = 5'd2,   SHL = 5'd3,
      SHR = 5'd4,  BAND = 5'd5, BOR = 5'd6,   BXOR = 5'd7,
      LAND = 5'd8, LOR = 5'd9,  EQ = 5'd10,   NE = 5'd11,
      GE = 5'd12,  LE = 5'd13,  GT = 5'd14,   LT = 5'd15,
      NEG = 5'd16, BNOT = 5'd17, LNOT = 5'd18,
      DUP      = 5'b10011,
      DROP     = 5'b10111,
      DROPNEXT = 5'b11011,
      OVER     = 5'b11111
   } alu_func_e;

   typedef enum logic [1:0] {
      IDLE_A = 2'b00,
      IDLE_B = 2'b01,   // Fetch of first word
      EXEC   = 2'b10
   } run_state_e;

endpackage

`default_nettype wire

/* logic/mem_pkg.sv */
`default_nettype none

// Storage sizes of the core
package mem_pkg;

   localparam int ADDR_W      = 12;
   localparam int RAM_WORDS   = 1 << ADDR_W;           // 4096 words
   localparam int STACK_DEPTH = 8;
   localparam int SP_W        = $clog2(STACK_DEPTH);
   localparam int N_PORTS     = 4;                     // In and out each
   localparam int PSEL_W      = $clog2(N_PORTS);

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [SP_W-1:0]   sp_t;
   typedef logic [PSEL_W-1:0] port_sel_t;

endpackage

`default_nettype wire

/* logic/program_ram.sv */
`default_nettype none

// 4K word program and data RAM
module program_ram
   import isa_pkg::*;
   import mem_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   input  wire        busy,
   input  wire addr_t pc_next,    // Fetch address
   input  wire addr_t abus,       // Core data address
   input  wire word_t dbus,
   input  wire        ram_we,
   output word_t      instr,
   output word_t      ram_q,
   // Wishbone slave
   input  wire        wb_cyc,
   input  wire        wb_stb,
   input  wire        wb_we,
   input  wire addr_t wb_adr,
   input  wire word_t wb_dat_w,
   output word_t      wb_dat_r,
   output logic       wb_ack
);

   word_t mem [RAM_WORDS];
   logic  wb_take;     // Host cycle accepted
   addr_t addr_a;
   word_t din_a;
   logic  we_a;

   // Host owns the data port only while the core is idle
   assign wb_take = wb_cyc && wb_stb && !busy && !wb_ack;
   assign addr_a  = busy ? abus : wb_adr;
   assign din_a   = busy ? dbus : wb_dat_w;
   assign we_a    = busy ? ram_we : (wb_take && wb_we);

   ////////////////////
   // Data port
   always_ff @(posedge clk)
   begin
      if (we_a)
         mem[addr_a] <= din_a;
      ram_q <= mem[addr_a];   // Old data on a write
   end

   // Fetch port
   always_ff @(posedge clk)
   begin
      instr <= mem[pc_next];
   end

   always_ff @(posedge clk or negedge reset)
   begin
      if (!reset)
         wb_ack <= 1'b0;
      else
         wb_ack <= wb_take;   // One cycle pulse
   end

   assign wb_dat_r = ram_q;

   a_ack_stb: assert property (@(posedge clk) disable iff (!reset)
      wb_ack |-> (wb_cyc && wb_stb));

endmodule

`default_nettype wire

/* logic/stack_alu.sv */
`default_nettype none

// Combinational ALU, b is next and a is top
module stack_alu
   import isa_pkg::*;
(
   input  wire word_t     a,
   input  wire word_t     b,
   input  wire alu_func_e func,
   output word_t          s
);

   logic signed [2*WORD_W-1:0] prod;
   word_t                      mul_s;

   ////////////////////
   // 10.8 multiply
   assign prod  = $signed(b) * $signed(a);
   assign mul_s = {prod[2*WORD_W-1], prod[WORD_W-2+FRAC_BITS:FRAC_BITS]};   // Sign kept

   always_comb
   begin
      case (func)
         ADD:  s = b + a;
         SUB:  s = b - a;
         MUL:  s = mul_s;
         SHL:  s = b << a;
         SHR:  s = b >> a;
         BAND: s = b & a;
         BOR:  s = b | a;
         BXOR: s = b ^ a;
         LAND: s = word_t'(b != '0 && a != '0);
         LOR:  s = word_t'(b != '0 || a != '0);
         EQ:   s = word_t'(b == a);
         NE:   s = word_t'(b != a);
         // Signed compares
         GE:   s = word_t'($signed(b) >= $signed(a));
         LE:   s = word_t'($signed(b) <= $signed(a));
         GT:   s = word_t'($signed(b) > $signed(a));
         LT:   s = word_t'($signed(b) < $signed(a));
         NEG:  s = -a;
         BNOT: s = ~a;
         LNOT: s = word_t'(a == '0);
         DUP, DROPNEXT:
            s = a;          // Top survives
         DROP, OVER:
            s = b;          // Next becomes top
         default:
            s = '0;
      endcase
   end

endmodule

`default_nettype wire

/* logic/stack_cpu_top.sv */
`default_nettype none

// Stack machine core with Wishbone program load
module stack_cpu_top
   import isa_pkg::*;
   import mem_pkg::*;
(
   input  wire        clk,
   input  wire        reset,
   input  wire        run,
   output wire        busy,
   input  wire word_t in_port0,
   input  wire word_t in_port1,
   input  wire word_t in_port2,
   input  wire word_t in_port3,
   output wire word_t out_port0,
   output wire word_t out_port1,
   output wire word_t out_port2,
   output wire word_t out_port3,
   // Wishbone host
   input  wire        wb_cyc,
   input  wire        wb_stb,
   input  wire        wb_we,
   input  wire addr_t wb_adr,
   input  wire word_t wb_dat_w,
   output wire word_t wb_dat_r,
   output wire        wb_ack
);

   word_t     instr;
   word_t     ram_q;
   word_t     alu_s;
   word_t     in_data;
   alu_func_e func;
   addr_t     pc_next;
   addr_t     abus;
   word_t     dbus;
   logic      ram_we;
   logic      out_we;
   port_sel_t port_sel;

   stack_if stk_bus ();

   assign stk_bus.dthru = ram_q;   // Read-through from data port

   cpu_control u_ctrl (
      .clk(clk), .reset(reset), .run(run), .busy(busy), .stk(stk_bus.ctrl),
      .instr(instr), .ram_q(ram_q), .alu_s(alu_s), .in_data(in_data),
      .func(func), .pc_next(pc_next), .abus(abus), .dbus(dbus),
      .ram_we(ram_we), .out_we(out_we), .port_sel(port_sel)
   );

   data_stack u_stack (.clk(clk), .reset(reset), .stk(stk_bus.stk));

   stack_alu u_alu (.a(stk_bus.qtop), .b(stk_bus.qnext), .func(func), .s(alu_s));

   program_ram u_ram (
      .clk(clk), .reset(reset), .busy(busy), .pc_next(pc_next), .abus(abus),
      .dbus(dbus), .ram_we(ram_we), .instr(instr), .ram_q(ram_q),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   io_ports u_io (
      .clk(clk), .reset(reset), .out_we(out_we), .port_sel(port_sel), .dbus(dbus),
      .in_port0(in_port0), .in_port1(in_port1), .in_port2(in_port2), .in_port3(in_port3),
      .in_data(in_data),
      .out_port0(out_port0), .out_port1(out_port1),
      .out_port2(out_port2), .out_port3(out_port3)
   );

endmodule

`default_nettype wire

/* logic/stack_if.sv */
`default_nettype none

// Decoder to data stack link
interface stack_if
   import isa_pkg::*;
();

   logic  push;    // New entry above top
   logic  pop;     // Drop one
   logic  pop2;    // Drop two, for ST
   logic  load;    // Write d to the new top
   logic  thru;    // RAM read lands on stack next cycle
   word_t d;
   word_t dthru;   // Registered RAM data port
   word_t qtop;
   word_t qnext;

   modport ctrl (output push, pop, pop2, load, thru, d, input qtop, qnext);

   modport stk (input push, pop, pop2, load, thru, d, dthru, output qtop, qnext);

endinterface

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
   --top-module tb_stack_cpu -f verilog.f -o tb_stack_cpu

sim_out="$(./obj_dir/tb_stack_cpu)"
echo "$sim_out"

if grep -q "Simulation PASSED" <<< "$sim_out"; then
   exit 0
else
   exit 1
fi

/* verilog.f */
logic/isa_pkg.sv
logic/mem_pkg.sv
logic/stack_if.sv
logic/data_stack.sv
logic/stack_alu.sv
logic/program_ram.sv
logic/cpu_control.sv
logic/io_ports.sv
logic/stack_cpu_top.sv
bench/tb_stack_cpu.sv
